//--- core_macros.svh
// core configuration: datapath widths, reset values, bubble word, exception vectors
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_XLEN      32          // data width
`define INSTR_W        16          // instruction word width
`define REG_CNT        16          // general registers

`define NOP_WORD       16'h3000    // bubble word
`define RESET_PC       32'h0000_0000
`define RESET_VBR      32'h0000_0100

// vector offsets from VBR, picked by exception code bits 14:13
`define VEC_OFS_FAULT  32'h08      // 00
`define VEC_OFS_IRQ0   32'h10      // 10
`define VEC_OFS_IRQ1   32'h18      // 01
`define VEC_OFS_IRQ2   32'h20      // 11

`define SR_IE_BIT      3           // interrupt enable
`define SR_BL_BIT      28          // block bit, lowest of the 30:28 group

`endif

//--- corePkg.sv
// core types: fetch status, opcodes and the payloads that move between stages
`include "core_macros.svh"

package corePkg;

	// fetch port status, same encoding as the memory side
	typedef enum logic [1:0]
	{
		MEM_READY = 2'b00,
		MEM_OK    = 2'b01,
		MEM_HOLD  = 2'b10
	} memStatusT;

	typedef enum logic [3:0]
	{
		OP_MOVI   = 4'h0,
		OP_ADD    = 4'h1,
		OP_SUB    = 4'h2,
		OP_NOP    = 4'h3,
		OP_BRA    = 4'h4,
		OP_TRAPA  = 4'h5,
		OP_MOVVBR = 4'h6,
		OP_MOVEXC = 4'h7,
		OP_MOVSR  = 4'h8
	} opcodeT;

	typedef struct packed
	{
		logic [`INSTR_W-1:0]   word;        // raw instruction
		logic [`CORE_XLEN-1:0] pc;          // address it came from
	} fetchT;

	typedef struct packed
	{
		opcodeT                      op;
		logic [$clog2(`REG_CNT)-1:0] rn;
		logic [$clog2(`REG_CNT)-1:0] rm;
		logic [`CORE_XLEN-1:0]       imm;   // sign extended imm8
		logic [`CORE_XLEN-1:0]       pc;
		logic                        valid;
	} uopT;

	typedef struct packed
	{
		uopT                   uop;
		logic [`CORE_XLEN-1:0] rnVal;
		logic [`CORE_XLEN-1:0] rmVal;
	} exOpT;

	typedef struct packed
	{
		logic                        valid;
		logic [$clog2(`REG_CNT)-1:0] regIdx;  // destination
		logic [`CORE_XLEN-1:0]       data;
	} wbT;

	typedef struct packed
	{
		logic                  taken;
		logic [`CORE_XLEN-1:0] target;
	} redirT;

	typedef struct packed
	{
		logic                  trap;
		logic [15:0]           trapCode;    // 0x8000 | imm8
		logic                  vbrWr;
		logic                  srWr;
		logic [`CORE_XLEN-1:0] value;       // new VBR or SR
	} sysReqT;

endpackage

//--- pipeStage.sv
// pipeline stage register that freezes on hold and drops to a bubble on flush
`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadT = logic [7:0],
	parameter payloadT bubble = '0
) (
	input  logic    clock,
	input  logic    rstN,
	input  logic    hold,     // freeze that wins over flush
	input  logic    flush,    // replace contents by bubble
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			q <= bubble;                // stages come up empty
		else if (hold)
			q <= q;
		else if (flush)
			q <= bubble;
		else
			q <= d;
	end

	// a stuck-unknown hold would corrupt every stage at once
	holdKnown: assert property (@(posedge clock) disable iff (!rstN) !$isunknown(hold));

	// a flush under hold would be lost since hold wins
	noFlushInHold: assert property (@(posedge clock) disable iff (!rstN) !(flush && hold));

endmodule

//--- instrDecoder.sv
// ID1 decoder, splits a fetched 16-bit word into a micro-op
`timescale 1ns/1ps
`include "core_macros.svh"

module instrDecoder (
	input  corePkg::fetchT fetch,
	output corePkg::uopT   uop
);
	import corePkg::*;

	logic [`INSTR_W-1:0] word;
	logic [7:0]          imm8;

	assign word = fetch.word;
	assign imm8 = word[7:0];

	always_comb
	begin
		uop       = '0;
		uop.rn    = word[11:8];
		uop.rm    = word[7:4];
		uop.imm   = {{(`CORE_XLEN-8){imm8[7]}}, imm8};  // sign extend
		uop.pc    = fetch.pc;

		case (word[15:12])
			4'h0:    uop.op = OP_MOVI;
			4'h1:    uop.op = OP_ADD;
			4'h2:    uop.op = OP_SUB;
			4'h4:    uop.op = OP_BRA;
			4'h5:    uop.op = OP_TRAPA;
			4'h6:    uop.op = OP_MOVVBR;
			4'h7:    uop.op = OP_MOVEXC;
			4'h8:    uop.op = OP_MOVSR;
			default: uop.op = OP_NOP;               // 3 and undefined codes
		endcase

		// bubbles and undefined words never reach EX as real work
		uop.valid = (uop.op != OP_NOP);
	end

endmodule

//--- regFile.sv
// general register file, 16 x 32, write-through read, registered commit output
`timescale 1ns/1ps
`include "core_macros.svh"

module regFile (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic [$clog2(`REG_CNT)-1:0]    rnIdx,
	input  logic [$clog2(`REG_CNT)-1:0]    rmIdx,
	output logic [`CORE_XLEN-1:0]          rnVal,
	output logic [`CORE_XLEN-1:0]          rmVal,
	input  corePkg::wbT                    wbIn,
	input  logic                           commit,
	output corePkg::wbT                    wbOut
);
	import corePkg::*;

	logic [`CORE_XLEN-1:0] regs [`REG_CNT];
	logic                  wrEn;

	assign wrEn = commit && wbIn.valid;

	// EX result bypasses into the ID2 read in the same cycle
	assign rnVal = (wrEn && (wbIn.regIdx == rnIdx)) ? wbIn.data : regs[rnIdx];
	assign rmVal = (wrEn && (wbIn.regIdx == rmIdx)) ? wbIn.data : regs[rmIdx];

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
			wbOut <= '0;
		end
		else
		begin
			if (wrEn)
				regs[wbIn.regIdx] <= wbIn.data;
			wbOut.valid  <= wrEn;               // one pulse per committed write
			wbOut.regIdx <= wbIn.regIdx;
			wbOut.data   <= wbIn.data;
		end
	end

	// the ALU must name a real register whenever its write is accepted
	wbIdxKnown: assert property (@(posedge clock) disable iff (!rstN)
		(wbIn.valid && commit) |-> !$isunknown(wbIn.regIdx));

endmodule

//--- aluExec.sv
// EX stage: arithmetic results, branch target, trap and system register requests
`timescale 1ns/1ps
`include "core_macros.svh"

module aluExec (
	input  corePkg::exOpT           exOp,
	input  logic [`CORE_XLEN-1:0]   exsr,
	output corePkg::wbT             wb,
	output corePkg::redirT          redir,
	output corePkg::sysReqT         sysReq
);
	import corePkg::*;

	localparam logic [`CORE_XLEN-1:0] PC_STEP = 2;

	uopT u;

	assign u = exOp.uop;

	always_comb
	begin
		wb     = '0;
		redir  = '0;
		sysReq = '0;

		wb.regIdx       = u.rn;
		redir.target    = u.pc + PC_STEP + (u.imm << 1);  // pc + 2 + 2*disp
		sysReq.trapCode = 16'h8000 | {8'h00, u.imm[7:0]};
		sysReq.value    = exOp.rnVal;                    // MOVVBR / MOVSR source

		// requests go out raw, flowCtl decides if they count
		if (u.valid)
		begin
			case (u.op)
				OP_MOVI:
				begin
					wb.valid = 1'b1;
					wb.data  = u.imm;
				end
				OP_ADD:
				begin
					wb.valid = 1'b1;
					wb.data  = exOp.rnVal + exOp.rmVal;
				end
				OP_SUB:
				begin
					wb.valid = 1'b1;
					wb.data  = exOp.rnVal - exOp.rmVal;
				end
				OP_MOVEXC:
				begin
					wb.valid = 1'b1;
					wb.data  = {16'h0000, exsr[15:0]};       // code half only
				end
				OP_BRA:    redir.taken   = 1'b1;
				OP_TRAPA:  sysReq.trap   = 1'b1;
				OP_MOVVBR: sysReq.vbrWr  = 1'b1;
				OP_MOVSR:  sysReq.srWr   = 1'b1;
				default:   wb.valid      = 1'b0;             // nop
			endcase
		end
	end

endmodule

//--- flowCtl.sv
// pipeline flow control for PC, SR, VBR, EXSR, hold, flush and trap or interrupt entry
`timescale 1ns/1ps
`include "core_macros.svh"

module flowCtl (
	input  logic                   clock,
	input  logic                   rstN,
	input  corePkg::memStatusT     fetchStatus,
	input  logic [`CORE_XLEN-1:0]  exPc,
	input  logic                   exValid,
	input  corePkg::redirT         redir,
	input  corePkg::sysReqT        sysReq,
	input  logic [15:0]            irqCode,
	output logic [`CORE_XLEN-1:0]  pc,
	output logic [`CORE_XLEN-1:0]  exsr,
	output logic                   hold,
	output logic                   flush,
	output logic                   commit,
	output logic                   irqAck
);
	import corePkg::*;

	localparam logic [`CORE_XLEN-1:0] PC_STEP = 2;

	logic [`CORE_XLEN-1:0] sr;
	logic [`CORE_XLEN-1:0] vbr;
	logic                  irqPend;    // normal irq allowed by SR and EX
	logic                  irqTake;
	logic                  trapTake;
	logic                  branchTake;
	logic [15:0]           excCode;
	logic [`CORE_XLEN-1:0] vecOfs;

	// exception class to vector offset
	function automatic logic [`CORE_XLEN-1:0] vecOffset(input logic [1:0] cls);
		case (cls)
			2'b00:   return `VEC_OFS_FAULT;
			2'b10:   return `VEC_OFS_IRQ0;
			2'b01:   return `VEC_OFS_IRQ1;
			default: return `VEC_OFS_IRQ2;
		endcase
	endfunction

	assign hold = (fetchStatus != MEM_OK);         // READY or HOLD stalls everything

	assign irqPend = irqCode[15] && irqCode[14] && sr[`SR_IE_BIT] && !sr[`SR_BL_BIT] &&
		exValid;
	assign irqTake    = irqPend && !hold;
	assign commit     = !hold && !irqTake;            // irq cancels the EX op
	assign trapTake   = commit && sysReq.trap;
	assign branchTake = commit && redir.taken;
	assign flush      = irqTake || trapTake || branchTake;
	assign irqAck     = irqTake;

	assign excCode = irqTake ? irqCode : sysReq.trapCode;
	assign vecOfs  = vecOffset(excCode[14:13]);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			pc   <= `RESET_PC;
			sr   <= '0;
			vbr  <= `RESET_VBR;
			exsr <= '0;
		end
		else if (!hold)
		begin
			if (irqTake || trapTake)
			begin
				pc        <= vbr + vecOfs;
				sr[30:28] <= 3'b111;                  // block further entry
				exsr      <= {exPc[15:0], excCode};   // faulting pc over code
			end
			else if (branchTake)
				pc <= redir.target;
			else
			begin
				pc <= pc + PC_STEP;
				if (commit && sysReq.vbrWr)
					vbr <= sysReq.value;
				if (commit && sysReq.srWr)
					sr <= sysReq.value;
			end
		end
	end

	// an accepted interrupt blocks further entry and leaves its class code in EXSR
	irqAckValid: assert property (@(posedge clock) disable iff (!rstN)
		irqAck |=> !irqAck && sr[`SR_BL_BIT] && exsr[15]);

endmodule

//--- exUnitTop.sv
// core top: IF, ID1, ID2 and EX stages around the register file and flow control
`timescale 1ns/1ps
`include "core_macros.svh"

module exUnitTop (
	input  logic                   clock,
	input  logic                   rstN,
	output logic [`CORE_XLEN-1:0]  fetchAddr,
	input  logic [`INSTR_W-1:0]    fetchWord,
	input  corePkg::memStatusT     fetchStatus,
	input  logic [15:0]            irqCode,
	output logic                   irqAck,
	output corePkg::wbT            wb
);
	import corePkg::*;

	localparam fetchT ID1_BUBBLE = '{word: `NOP_WORD, pc: '0};
	localparam uopT   ID2_BUBBLE = '{op: OP_NOP, rn: '0, rm: '0, imm: '0, pc: '0,
		valid: 1'b0};
	localparam exOpT  EX_BUBBLE  = '{uop: ID2_BUBBLE, rnVal: '0, rmVal: '0};

	logic                  hold;
	logic                  flush;
	logic                  commit;
	logic [`CORE_XLEN-1:0] exsr;
	logic [`CORE_XLEN-1:0] rnVal;
	logic [`CORE_XLEN-1:0] rmVal;
	fetchT                 fetchIn;     // IF word with its pc
	fetchT                 id1Q;
	uopT                   decUop;
	uopT                   id2Q;
	exOpT                  exIn;
	exOpT                  exQ;
	wbT                    aluWb;
	redirT                 redir;
	sysReqT                sysReq;

	assign fetchIn = '{word: fetchWord, pc: fetchAddr};
	assign exIn    = '{uop: id2Q, rnVal: rnVal, rmVal: rmVal};

	pipeStage #(.payloadT(fetchT), .bubble(ID1_BUBBLE)) stgId1 (
		.clock(clock), .rstN(rstN), .hold(hold), .flush(flush), .d(fetchIn), .q(id1Q));

	instrDecoder decoder (.fetch(id1Q), .uop(decUop));

	pipeStage #(.payloadT(uopT), .bubble(ID2_BUBBLE)) stgId2 (
		.clock(clock), .rstN(rstN), .hold(hold), .flush(flush), .d(decUop), .q(id2Q));

	regFile regs (
		.clock(clock), .rstN(rstN), .rnIdx(id2Q.rn), .rmIdx(id2Q.rm),
		.rnVal(rnVal), .rmVal(rmVal), .wbIn(aluWb), .commit(commit), .wbOut(wb));

	pipeStage #(.payloadT(exOpT), .bubble(EX_BUBBLE)) stgEx (
		.clock(clock), .rstN(rstN), .hold(hold), .flush(flush), .d(exIn), .q(exQ));

	aluExec alu (.exOp(exQ), .exsr(exsr), .wb(aluWb), .redir(redir), .sysReq(sysReq));

	flowCtl flow (
		.clock(clock), .rstN(rstN), .fetchStatus(fetchStatus),
		.exPc(exQ.uop.pc), .exValid(exQ.uop.valid),
		.redir(redir), .sysReq(sysReq), .irqCode(irqCode),
		.pc(fetchAddr), .exsr(exsr), .hold(hold), .flush(flush),
		.commit(commit), .irqAck(irqAck));

endmodule

//--- tbExUnit.sv
// testbench for the core: fetch memory model, random fetch holds, interrupt driver, writeback checks
`timescale 1ns/1ps
`include "core_macros.svh"

module tbExUnit;
	import corePkg::*;

	localparam int TIMEOUT_CYCLES = 3000;
	localparam int IDLE_CYCLES    = 40;    // quiet tail, program parks in a self loop

	logic                  clock;
	logic                  rstN;
	logic [`CORE_XLEN-1:0] fetchAddr;
	logic [`INSTR_W-1:0]   fetchWord;
	memStatusT             fetchStatus = MEM_HOLD;
	logic [15:0]           irqCode = '0;
	logic                  irqAck;
	wbT                    wb;

	logic [`INSTR_W-1:0] progMem [256];
	logic [3:0]          expReg [$];
	logic [31:0]         expData [$];
	logic [31:0]         irqAfter [$];     // writebacks seen before the request goes up
	logic [15:0]         irqVal [$];
	logic [31:0]         irqGate [$];      // writebacks needed before an ack is legal
	integer              seed = 70384;
	int                  wbCount = 0;
	int                  ackCount = 0;
	logic                ackLast = 1'b0;
	logic                holdAtEdge = 1'b1;
	logic                runFetch = 1'b0;

	exUnitTop dut (
		.clock(clock), .rstN(rstN), .fetchAddr(fetchAddr), .fetchWord(fetchWord),
		.fetchStatus(fetchStatus), .irqCode(irqCode), .irqAck(irqAck), .wb(wb));

	assign fetchWord = progMem[fetchAddr[8:1]];    // combinational fetch memory

	task automatic abortRun(input string reason);
		$display("test failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkVal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
			abortRun("value mismatch");
		end
	endtask

	task automatic loadStimulus();
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;

		for (int a = 0; a < 256; a++)
			progMem[a] = {8'h0F, a[7:0]};           // stray fetch turns into MOVI r15, index
		fd = $fopen("exUnit_stim.txt", "r");
		if (fd == 0)
			abortRun("cannot open the stimulus file exUnit_stim.txt");
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 2)
				begin
					kind = line.getc(0);
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f0, f1, f2);
					case (kind)
						"P": progMem[f0[8:1]] = f1[15:0];
						"I":
						begin
							irqAfter.push_back(f0);
							irqVal.push_back(f1[15:0]);
							irqGate.push_back(f2);
						end
						"W":
						begin
							expReg.push_back(f0[3:0]);
							expData.push_back(f1);
						end
						default: ;                       // comment lines
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// raise each interrupt after its writeback count, drop it on the edge after the ack
	task automatic driveIrq();
		int waited;

		for (int i = 0; i < irqVal.size(); i++)
		begin
			waited = 0;
			do
			begin
				@(posedge clock);
				waited++;
			end
			while (wbCount < irqAfter[i] && waited < TIMEOUT_CYCLES);
			if (wbCount < irqAfter[i])
				abortRun("timeout waiting for writebacks before raising the interrupt");
			else
			begin
				irqCode <= irqVal[i];
				waited = 0;
				do
				begin
					@(posedge clock);
					waited++;
				end
				while (ackCount <= i && waited < TIMEOUT_CYCLES);
				if (ackCount <= i)
					abortRun("timeout waiting for irqAck");
				else
					irqCode <= '0;                       // take edge already saw the code
			end
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// fetch back-pressure, HOLD in about one cycle of four
	always @(posedge clock)
	begin
		holdAtEdge <= (fetchStatus == MEM_HOLD);     // status seen by the DUT at this edge
		if (runFetch && (($random(seed) & 3) != 0))
			fetchStatus <= MEM_OK;
		else
			fetchStatus <= MEM_HOLD;
	end

	// wb and irqAck are settled by the falling edge
	always @(negedge clock)
	begin
		if (rstN)
		begin
			if (holdAtEdge)
				checkVal("wb.valid after a hold edge", {31'h0, wb.valid}, 32'h0);
			if (wb.valid)
			begin
				if (wbCount >= expData.size())
					abortRun("writeback beyond the expected list");
				else
				begin
					checkVal("wb.regIdx", {28'h0, wb.regIdx}, {28'h0, expReg[wbCount]});
					checkVal("wb.data", wb.data, expData[wbCount]);
					wbCount++;
				end
			end
			if (irqAck)
			begin
				if (ackLast || ackCount >= irqVal.size())
					abortRun("irqAck pulsed with no interrupt outstanding");
				else if (wbCount < irqGate[ackCount])
					abortRun("irqAck came while interrupts should still be masked");
				else
					ackCount++;
			end
			ackLast = irqAck;
		end
	end

	initial
	begin
		int waited;

		rstN = 1'b0;
		loadStimulus();
		repeat (5) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		// status still HOLD, nothing fetched yet
		checkVal("fetchAddr", fetchAddr, `RESET_PC);
		checkVal("wb.valid", {31'h0, wb.valid}, 32'h0);
		checkVal("irqAck", {31'h0, irqAck}, 32'h0);
		runFetch = 1'b1;
		fork
			driveIrq();
		join_none
		waited = 0;
		while (wbCount < expData.size() && waited < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			waited++;
		end
		if (wbCount < expData.size())
			abortRun("timeout waiting for the expected writebacks");
		else
		begin
			repeat (IDLE_CYCLES) @(posedge clock);   // any late writeback trips the monitor
			if (ackCount == irqVal.size())
			begin
				$display("test passed");
				$finish;
			end
			else
				abortRun("an interrupt was never acknowledged");
		end
	end

endmodule

//--- exUnit_stim.txt
# columns: P addr word | I after code gate | W reg data, all values hex
# I raises irqCode after <after> writebacks, its ack may not come before <gate> writebacks
P 00 0105  # movi r1, 5
P 02 0203  # movi r2, 3
P 04 1120  # add r1, r2
P 06 2120  # sub r1, r2
P 08 1210  # add r2, r1
P 0A 03FE  # movi r3, -2
P 0C 1310  # add r3, r1
P 0E 2430  # sub r4, r3
P 10 4003  # bra 18
P 12 0711  # skipped
P 14 0722  # skipped
P 16 0733  # skipped
P 18 1420  # add r4, r2
P 1A 0540  # movi r5, 40
P 1C 6500  # movvbr r5
P 1E 502A  # trapa 2a, vector 48
P 20 0744  # skipped
P 22 0755  # skipped
P 24 0808  # movi r8, 8
P 26 8800  # movsr r8, ie on, bl off
P 28 0966  # cancelled by the interrupt
P 2A 0977  # flushed
P 48 7600  # trap handler, movexc r6
P 4A 40EC  # bra 24
P 50 7A00  # irq handler at 40 + 10, movexc r10
P 52 1A10  # add r10, r1
P 54 40FF  # bra to self
I 2 C021 C
W 1 00000005
W 2 00000003
W 1 00000008
W 1 00000005
W 2 00000008
W 3 FFFFFFFE
W 3 00000003
W 4 FFFFFFFD
W 4 00000005
W 5 00000040
W 6 0000802A
W 8 00000008
W A 0000C021
W A 0000C026

//--- filelist.f
+incdir+.
corePkg.sv
pipeStage.sv
instrDecoder.sv
regFile.sv
aluExec.sv
flowCtl.sv
exUnitTop.sv
tbExUnit.sv

//--- Makefile
TOP = tbExUnit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
